//--- bench/usiCases.txt
# Columns: opcode (W write, R read and compare, P poll until equal), CSR address, value, in hex
# Each comment line opens a group; lines inside a group run back to back
# Reset values, VD shows both slaves ready
R 00 00000000
R 04 00000000
R 08 00000000
R 0C 00000000
R 10 00000003
# Manual registers, ADRS keeps 16 bits, WCKE keeps bit 0
W 00 12345678
W 04 ABCD1234
W 08 FFFFFFFE
R 00 12345678
R 04 00001234
R 08 00000000
# Slave 0 register 2, full word
W 04 00000008
W 00 DEADBEEF
W 08 00000001
P 08 00000000
R 0C DEADBEEF
# Slave 1 register 2, half word payload
W 04 00000108
W 00 CAFEF00D
W 08 00000001
P 08 00000000
R 0C 0000F00D
# Slave 1 back to back, second command waits out the busy window
W 04 00000100
W 00 1111AAAA
W 08 00000001
W 00 2222BBBB
W 04 00000104
W 08 00000001
R 10 00000001
# Both slave 1 registers
P 08 00000000
W 04 00000100
R 04 00000100
R 0C 0000AAAA
W 04 00000104
R 04 00000104
R 0C 0000BBBB
# Unmapped slave index 5
W 04 00000508
W 00 55AA55AA
W 08 00000001
P 08 00000000
R 0C 00000000
R 10 00000003

//--- all.f
+incdir+src
src/usiBusPkg.sv
src/csrPkg.sv
src/microControllerCsr.sv
src/usiBusFabric.sv
src/usiSlaveRegFile.sv
src/usiSubsystemTop.sv
bench/usiSubsystemChecker.sv
bench/usiSubsystemTb.sv

//--- Bender.yml
package:
  name: usi_subsystem

export_include_dirs:
  - src

sources:
  # Design
  - src/usiBusPkg.sv
  - src/csrPkg.sv
  - src/microControllerCsr.sv
  - src/usiBusFabric.sv
  - src/usiSlaveRegFile.sv
  - src/usiSubsystemTop.sv
  # Testbench
  - target: test
    files:
      - bench/usiSubsystemChecker.sv
      - bench/usiSubsystemTb.sv

//--- bench/usiSubsystemTb.sv
//------------------------------
// USI subsystem testbench, CSR traffic from a case file
//------------------------------
`default_nettype none

module usiSubsystemTb
	import usiBusPkg::*;
();

	// Processor port
	logic       iSysClk;
	logic       rst;
	logic [7:0] adrs;
	usiWord_t   wd;
	logic       cke;
	usiWord_t   rd;

	//------------------------------
	// Case table
	//------------------------------
	byte         opQ[$];
	logic [7:0]  adrsQ[$];
	usiWord_t    valQ[$];
	// Set on the first line of a group
	bit          groupQ[$];
	int          caseCount;
	bit          casesLoaded;
	// Bookkeeping
	int          checkCount;
	int          errCount;
	logic [31:0] randState;

	usiSubsystemTop UUT (
		.iSysClk(iSysClk), .rst(rst),
		.adrs(adrs), .wd(wd), .cke(cke), .rd(rd)
	);

	always #4 iSysClk = ~iSysClk;

	// Idle gap source
	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic checkValue(input string name, input usiWord_t got, input usiWord_t expected);
		checkCount++;
		if (got !== expected)
		begin
			errCount++;
			$display("Fail %s: got 0x%08h, expected 0x%08h", name, got, expected);
		end
	endtask

	//------------------------------
	// Processor port drivers
	//------------------------------
	task automatic idleCycles(input int count);
		repeat (count)
		begin
			@(posedge iSysClk);
			cke <= 1'b0;
		end
	endtask

	// One-cycle write, the next edge drops cke
	task automatic csrWrite(input logic [7:0] a, input usiWord_t v);
		@(posedge iSysClk);
		adrs <= a;
		wd   <= v;
		cke  <= 1'b1;
	endtask

	task automatic csrRead(input logic [7:0] a, input usiWord_t expected);
		@(posedge iSysClk);
		adrs <= a;
		cke  <= 1'b0;
		// rd loads on the next edge, stable by the falling one
		@(posedge iSysClk);
		@(negedge iSysClk);
		checkValue($sformatf("rd[csr 0x%02h]", a), rd, expected);
	endtask

	// Waits for a CSR to settle, used on WCKE
	task automatic csrPoll(input logic [7:0] a, input usiWord_t expected);
		int polls;
		polls = 0;
		@(posedge iSysClk);
		adrs <= a;
		cke  <= 1'b0;
		@(posedge iSysClk);
		@(negedge iSysClk);
		while (rd !== expected && polls < 20)
		begin
			@(negedge iSysClk);
			polls++;
		end
		if (rd !== expected)
		begin
			errCount++;
			$display("Bus write never completed, csr 0x%02h still reads 0x%08h after %0d cycles",
				a, rd, polls);
		end
	endtask

	//------------------------------
	// Case file
	//------------------------------
	task automatic loadCases(output bit ok);
		int         fd;
		int         fields;
		string      line;
		byte        op;
		logic [7:0] a;
		usiWord_t   v;
		bit         newGroup;
		ok = 1'b0;
		newGroup = 1'b1;
		fd = $fopen("bench/usiCases.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			if ($fgets(line, fd) == 0)
				break;
			// Comment lines open a new group
			if (line.len() > 0 && line[0] == "#")
				newGroup = 1'b1;
			else
			begin
				fields = $sscanf(line, " %c %h %h", op, a, v);
				if (fields == 3)
				begin
					opQ.push_back(op);
					adrsQ.push_back(a);
					valQ.push_back(v);
					groupQ.push_back(newGroup);
					newGroup = 1'b0;
				end
			end
		end
		$fclose(fd);
		ok = 1'b1;
	endtask

	task automatic runCases();
		for (int i = 0; i < caseCount; i++)
		begin
			// Random idle gap ahead of each group only
			if (groupQ[i])
			begin
				randState = lcgNext(randState);
				idleCycles(int'(randState[31:30]));
			end
			case (opQ[i])
				"W": csrWrite(adrsQ[i], valQ[i]);
				"R": csrRead(adrsQ[i], valQ[i]);
				"P": csrPoll(adrsQ[i], valQ[i]);
				default:
				begin
					errCount++;
					$display("Unknown opcode '%c' on case %0d", opQ[i], i);
				end
			endcase
		end
	endtask

	//------------------------------
	// Main sequence
	//------------------------------
	initial
	begin
		bit loaded;
		int assertFails;
		iSysClk     = 1'b0;
		rst         = 1'b1;
		adrs        = '0;
		wd          = '0;
		cke         = 1'b0;
		checkCount  = 0;
		errCount    = 0;
		casesLoaded = 1'b0;
		caseCount   = 0;
		randState   = 32'h3499_9a12;
		loadCases(loaded);
		if (!loaded || opQ.size() == 0)
		begin
			$display("Could not read any cases from bench/usiCases.txt");
			$display("*** TEST FAILED ***");
			$finish;
		end
		else
		begin
			caseCount   = opQ.size();
			casesLoaded = 1'b1;
			repeat (3) @(posedge iSysClk);
			rst <= 1'b0;
			runCases();
			idleCycles(2);
			assertFails = UUT.csr.handshakeChecker.assertFails;
			$display("Checks: %0d, value errors: %0d, assertion failures: %0d",
				checkCount, errCount, assertFails);
			if (errCount == 0 && assertFails == 0)
			begin
				$display("*** TEST PASSED ***");
			end
			else
			begin
				$display("*** TEST FAILED ***");
			end
			$finish;
		end
	end

	// Watchdog, scaled by the case count
	initial
	begin
		wait (casesLoaded);
		repeat (caseCount * 40) @(posedge iSysClk);
		$display("Watchdog expired after %0d cycles, the run did not finish", caseCount * 40);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/usiSubsystemChecker.sv
//------------------------------
// Bus handshake assertions, bound to the master CSR block
//------------------------------
`default_nettype none

module usiSubsystemChecker
	import usiBusPkg::*;
	import csrPkg::*;
(
	input  wire logic       iSysClk,
	input  wire logic       rst,
	// Processor write decode
	input  wire logic       cke,
	input  wire logic       selHit,
	input  var  csrRegSel_t regSel,
	// Bus command
	input  wire usiWord_t   busWd,
	input  wire usiAdrs_t   busAdrs,
	input  wire logic       busWValid,
	input  wire logic       busWReady
);

	// Failure count, summed into the closing report
	int assertFails = 0;

	// WCKE rewritten on this edge
	logic wckeWrite;

	assign wckeWrite = cke && selHit && (regSel == CSR_WCKE);

	//------------------------------
	// Handshake rules
	//------------------------------
	// Idle out of reset, a command only starts after a WCKE write
	resetIdle: assert property (@(posedge iSysClk) disable iff (rst)
		$rose(busWValid) |-> $past(wckeWrite))
	else
	begin
		assertFails++;
		$error("busWValid rose without a WCKE write");
	end

	// Command frozen while the slave stalls
	cmdStable: assert property (@(posedge iSysClk) disable iff (rst)
		(busWValid && !busWReady) |=> ($stable(busWd) && $stable(busAdrs)))
	else
	begin
		assertFails++;
		$error("busWd or busAdrs changed while the write was stalled");
	end

	// Command clears itself after the transfer
	cmdClear: assert property (@(posedge iSysClk) disable iff (rst)
		(busWValid && busWReady && !wckeWrite) |=> !busWValid)
	else
	begin
		assertFails++;
		$error("busWValid still high one cycle after a handshake");
	end

endmodule

bind microControllerCsr usiSubsystemChecker handshakeChecker (
	.iSysClk(iSysClk), .rst(rst),
	.cke(cke), .selHit(selHit), .regSel(regSel),
	.busWd(busWd), .busAdrs(busAdrs),
	.busWValid(busWValid), .busWReady(busWReady)
);

`default_nettype wire

//--- src/usiSubsystemTop.sv
//------------------------------
// USI subsystem top, CSR master plus two slaves
//------------------------------
`default_nettype none

`include "usiBusDefs.svh"

module usiSubsystemTop
	import usiBusPkg::*;
(
	input  wire logic       iSysClk,
	input  wire logic       rst,
	// Processor register port
	input  wire logic [7:0] adrs,
	input  wire usiWord_t   wd,
	input  wire logic       cke,
	output      usiWord_t   rd
);

	// Master to fabric
	usiWord_t busWd;
	usiAdrs_t busAdrs;
	logic     busWValid;
	logic     busWReady;
	usiWord_t busRd;
	usiVd_t   busVd;
	// Fabric to slaves
	logic [`USI_SLAVE_NUM-1:0] slvWValid;
	usiVd_t                    slvReady;
	usiWord_t                  slvRd0;
	usiWord_t                  slvRd1;

	microControllerCsr csr (
		.iSysClk(iSysClk), .rst(rst),
		.adrs(adrs), .wd(wd), .cke(cke), .rd(rd),
		.busWd(busWd), .busAdrs(busAdrs), .busWValid(busWValid),
		.busWReady(busWReady), .busRd(busRd), .busVd(busVd)
	);

	usiBusFabric fabric (
		.busAdrs(busAdrs), .busWValid(busWValid),
		.busWReady(busWReady), .busRd(busRd), .busVd(busVd),
		.slvWValid(slvWValid), .slvReady(slvReady),
		.slvRd0(slvRd0), .slvRd1(slvRd1)
	);

	// Slave 0, full words
	usiSlaveRegFile #(.tPayload(usiWord_t)) slave0 (
		.iSysClk(iSysClk), .rst(rst),
		.regSel(busAdrs[3:2]), .wd(busWd), .wValid(slvWValid[0]),
		.ready(slvReady[0]), .readData(slvRd0)
	);

	// Slave 1, half words
	usiSlaveRegFile #(.tPayload(usiHalf_t)) slave1 (
		.iSysClk(iSysClk), .rst(rst),
		.regSel(busAdrs[3:2]), .wd(busWd), .wValid(slvWValid[1]),
		.ready(slvReady[1]), .readData(slvRd1)
	);

endmodule

`default_nettype wire

//--- src/usiSlaveRegFile.sv
//------------------------------
// USI slave, four registers of a chosen payload
// Busy for a few cycles after each write
//------------------------------
`default_nettype none

`include "usiBusDefs.svh"

module usiSlaveRegFile
	import usiBusPkg::*;
#(
	parameter type tPayload    = usiWord_t,
	parameter int  pBusyCycles = `USI_BUSY_CYCLES
)(
	input  wire logic       iSysClk,
	input  wire logic       rst,
	// Bus side
	input  wire logic [1:0] regSel,
	input  wire usiWord_t   wd,
	input  wire logic       wValid,
	output      logic       ready,
	output      usiWord_t   readData
);

	localparam int cPayloadBits = $bits(tPayload);
	// At least one bit even with no busy window
	localparam int cCntBits     = (pBusyCycles < 1) ? 1 : $clog2(pBusyCycles + 1);

	tPayload               regFile [4];
	logic [cCntBits-1:0]   busyCnt;
	logic                  wAccept;

	assign wAccept = wValid && ready;

	//------------------------------
	// Register storage
	//------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 4; i++)
				regFile[i] <= '0;
		end
		else if (wAccept)
		begin
			// Upper bits of wd dropped for narrow payloads
			regFile[regSel] <= wd[cPayloadBits-1:0];
		end
	end

	//------------------------------
	// Busy window
	//------------------------------
	// Loaded on accept, counts down to ready
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			busyCnt <= '0;
		else if (wAccept)
			busyCnt <= cCntBits'(pBusyCycles);
		else if (busyCnt != '0)
			busyCnt <= busyCnt - 1'b1;
	end

	assign ready = (busyCnt == '0);

	// Read path, zero-extended to a bus word
	assign readData = usiWord_t'(regFile[regSel]);

endmodule

`default_nettype wire

//--- src/usiBusFabric.sv
//------------------------------
// USI bus fabric, slave decode and return path
//------------------------------
`default_nettype none

`include "usiBusDefs.svh"

module usiBusFabric
	import usiBusPkg::*;
(
	// From master
	input  wire usiAdrs_t                  busAdrs,
	input  wire logic                      busWValid,
	// To master
	output      logic                      busWReady,
	output      usiWord_t                  busRd,
	output      usiVd_t                    busVd,
	// Slave side
	output      logic [`USI_SLAVE_NUM-1:0] slvWValid,
	input  wire usiVd_t                    slvReady,
	input  wire usiWord_t                  slvRd0,
	input  wire usiWord_t                  slvRd1
);

	usiSlaveSel_t slvSel;

	assign slvSel = usiSlaveSelOf(busAdrs);

	//------------------------------
	// Write valid and ready
	//------------------------------
	// Unmapped index acts as a sink that is always ready
	always_comb
	begin
		busWReady = 1'b1;
		slvWValid = '0;
		for (int i = 0; i < `USI_SLAVE_NUM; i++)
		begin
			if (slvSel == usiSlaveSel_t'(i))
			begin
				slvWValid[i] = busWValid;
				busWReady    = slvReady[i];
			end
		end
	end

	//------------------------------
	// Read data return
	//------------------------------
	// Unmapped index reads zero
	always_comb
	begin
		case (slvSel)
			8'd0:    busRd = slvRd0;
			8'd1:    busRd = slvRd1;
			default: busRd = '0;
		endcase
	end

	// Every ready bit goes back as status
	assign busVd = slvReady;

endmodule

`default_nettype wire

//--- src/microControllerCsr.sv
//------------------------------
// Master CSR block, processor port to USI bus command
// Write command clears itself on handshake
//------------------------------
`default_nettype none

`include "usiBusDefs.svh"

module microControllerCsr
	import usiBusPkg::*;
	import csrPkg::*;
(
	input  wire logic     iSysClk,
	input  wire logic     rst,
	// Processor register port
	input  wire csrAdrs_t adrs,
	input  wire usiWord_t wd,
	input  wire logic     cke,
	output      usiWord_t rd,
	// Bus command
	output      usiWord_t busWd,
	output      usiAdrs_t busAdrs,
	output      logic     busWValid,
	input  wire logic     busWReady,
	// Bus status
	input  wire usiWord_t busRd,
	input  wire usiVd_t   busVd
);

	//------------------------------
	// Register map
	//------------------------------
	// Manual
	usiWord_t regWd;
	usiAdrs_t regAdrs;
	logic     regWCke;
	// Auto
	usiWord_t regRd;
	usiVd_t   regVd;

	// Address decode
	csrRegSel_t regSel;
	logic       selHit;

	always_comb
	begin
		selHit = 1'b1;
		regSel = CSR_WD;
		case (adrs)
			`CSR_ADRS_WD:   regSel = CSR_WD;
			`CSR_ADRS_ADRS: regSel = CSR_ADRS;
			`CSR_ADRS_WCKE: regSel = CSR_WCKE;
			`CSR_ADRS_RD:   regSel = CSR_RD;
			`CSR_ADRS_VD:   regSel = CSR_VD;
			default:        selHit = 1'b0;
		endcase
	end

	// Only the manual registers take processor writes
	always_ff @(posedge iSysClk)
	begin
		if (rst)
		begin
			regWd   <= '0;
			regAdrs <= '0;
			regWCke <= 1'b0;
			regRd   <= '0;
			regVd   <= '0;
		end
		else
		begin
			if (cke && selHit && regSel == CSR_WD)
				regWd <= wd;
			if (cke && selHit && regSel == CSR_ADRS)
				regAdrs <= wd[`USI_ADRS_BITS-1:0];
			// Processor write wins over the handshake clear
			if (cke && selHit && regSel == CSR_WCKE)
				regWCke <= wd[0];
			else if (regWCke && busWReady)
				regWCke <= 1'b0;
			// Status sampled every cycle
			regRd <= busRd;
			regVd <= busVd;
		end
	end

	assign busWd     = regWd;
	assign busAdrs   = regAdrs;
	assign busWValid = regWCke;

	//------------------------------
	// Processor read, one cycle latency
	//------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (rst)
			rd <= '0;
		else if (selHit)
		begin
			case (regSel)
				CSR_WD:   rd <= regWd;
				CSR_ADRS: rd <= usiWord_t'(regAdrs);
				CSR_WCKE: rd <= usiWord_t'(regWCke);
				CSR_RD:   rd <= regRd;
				CSR_VD:   rd <= usiWord_t'(regVd);
				default:  rd <= rd;
			endcase
		end
		// Unknown address keeps the last value
	end

endmodule

`default_nettype wire

//--- src/csrPkg.sv
//------------------------------
// Processor-side CSR address and register types
//------------------------------
`default_nettype none

package csrPkg;

	//------------------------------
	// Processor port address
	//------------------------------
	typedef logic [7:0] csrAdrs_t;

	//------------------------------
	// CSR registers
	//------------------------------
	// Manual registers, written by the processor
	//   CSR_WD    bus write data
	//   CSR_ADRS  bus address
	//   CSR_WCKE  bus write command, bit 0
	// Auto registers, refreshed every cycle
	//   CSR_RD    bus read data
	//   CSR_VD    slave ready vector
	typedef enum logic [2:0] {
		CSR_WD   = 3'd0,
		CSR_ADRS = 3'd1,
		CSR_WCKE = 3'd2,
		CSR_RD   = 3'd3,
		CSR_VD   = 3'd4
	} csrRegSel_t;

endpackage

`default_nettype wire

//--- src/usiBusPkg.sv
//------------------------------
// USI bus word, address and ready types
//------------------------------
`default_nettype none

`include "usiBusDefs.svh"

package usiBusPkg;

	// Bus payloads
	typedef logic [`USI_DATA_BITS-1:0] usiWord_t;
	typedef logic [15:0]               usiHalf_t;

	// Bus address
	// Bits 15..8 pick the slave, bits 3..2 pick the register
	typedef logic [`USI_ADRS_BITS-1:0] usiAdrs_t;

	// Slave index field
	typedef logic [7:0] usiSlaveSel_t;

	// One ready bit per slave
	typedef logic [`USI_SLAVE_NUM-1:0] usiVd_t;

	// Slave index out of a bus address
	function automatic usiSlaveSel_t usiSlaveSelOf(input usiAdrs_t adrs);
		return adrs[15:8];
	endfunction

endpackage

`default_nettype wire

//--- src/usiBusDefs.svh
//------------------------------
// USI bus widths, slave count and CSR address map
//------------------------------
`ifndef USI_BUS_DEFS_SVH
`define USI_BUS_DEFS_SVH

//------------------------------
// Bus geometry
//------------------------------
`define USI_DATA_BITS 32
`define USI_ADRS_BITS 16
// Also the width of the ready vector
`define USI_SLAVE_NUM 2

//------------------------------
// CSR map, processor side
//------------------------------
`define CSR_ADRS_WD   8'h00
`define CSR_ADRS_ADRS 8'h04
`define CSR_ADRS_WCKE 8'h08
// Status, read only
`define CSR_ADRS_RD   8'h0C
`define CSR_ADRS_VD   8'h10

// Slave back-pressure after an accepted write
`define USI_BUSY_CYCLES 3

`endif
